// File: hdl/core_pkg.sv
/*
  shared types for the rv64 pipeline. all memory traffic is 64-bit aligned words,
  so no size or byte-lane fields are carried between stages
*/
package core_pkg;

  parameter int xlen = 64;

  typedef logic [xlen-1:0] xword_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_idx_t;

  // major opcodes of the kept instructions
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_xor,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_t;

  typedef struct packed {
    xword_t pc;
    inst_t  inst;
  } fetch_t;

  typedef struct packed {
    xword_t   pc;
    alu_op_t  alu_op;
    xword_t   operand_a;
    xword_t   operand_b;
    xword_t   store_data;
    reg_idx_t rd;
    logic     reg_write;
    logic     is_load;
    logic     is_store;
  } decode_t;

  // result holds the alu value, or the address for loads and stores
  typedef struct packed {
    xword_t   pc;
    xword_t   result;
    xword_t   store_data;
    reg_idx_t rd;
    logic     reg_write;
    logic     is_load;
    logic     is_store;
  } exec_t;

endpackage

// File: hdl/pipe_slot.sv
/*
  one-entry pipeline register with valid/allowin flow control.
  full throughput only when the consumer takes the item in the cycle it is shown
*/
module pipe_slot #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_payload,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_payload
);

  logic     full;
  payload_t data;

  // room when empty or when the held item leaves this cycle
  assign in_ready    = !full || out_ready;
  assign out_valid   = full;
  assign out_payload = data;

  always_ff @(posedge clock) begin
    if (reset) begin
      full <= 1'b0;
    end else if (in_valid && in_ready) begin
      full <= 1'b1;
    end else if (out_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid && in_ready) begin
      data <= in_payload;
    end
  end

endmodule

// File: hdl/fetch_stage.sv
/*
  sequential fetch only, no redirect. imem_rdata must be valid in the handshake
  cycle since it goes straight into the next slot
*/
module fetch_stage import core_pkg::*; #(
  parameter xword_t reset_pc = '0
) (
  input  logic   clock,
  input  logic   reset,
  output logic   imem_valid,
  input  logic   imem_ready,
  output xword_t imem_addr,
  input  inst_t  imem_rdata,
  output logic   out_valid,
  input  logic   out_ready,
  output fetch_t out_payload
);

  xword_t pc;
  logic   running;
  logic   fire;

  // out_ready stays high until a push, so the request holds until the handshake
  assign imem_valid = running && out_ready;
  assign imem_addr  = pc;
  assign fire       = imem_valid && imem_ready;

  assign out_valid        = fire;
  assign out_payload.pc   = pc;
  assign out_payload.inst = imem_rdata;

  always_ff @(posedge clock) begin
    if (reset) begin
      running <= 1'b0;
      pc      <= reset_pc;
    end else begin
      running <= 1'b1;
      if (fire) begin
        pc <= pc + xword_t'(4);
      end
    end
  end

endmodule

// File: hdl/decode_stage.sv
/*
  decode and operand read. no forwarding: a source that matches any pending writer
  (ex slot, mem slot or the commit register) holds the instruction here
*/
module decode_stage import core_pkg::*; (
  input  logic     in_valid,
  output logic     in_ready,
  input  fetch_t   in_payload,
  output reg_idx_t rs1_addr,
  output reg_idx_t rs2_addr,
  input  xword_t   rs1_data,
  input  xword_t   rs2_data,
  input  logic     ex_busy,
  input  reg_idx_t ex_rd,
  input  logic     ex_write,
  input  logic     mem_busy,
  input  reg_idx_t mem_rd,
  input  logic     mem_write,
  input  logic     commit_valid,
  input  reg_idx_t commit_rd,
  input  logic     commit_write,
  output logic     out_valid,
  input  logic     out_ready,
  output decode_t  out_payload
);

  inst_t  inst;
  xword_t imm_i;
  xword_t imm_s;
  xword_t imm_u;
  logic   uses_rs1;
  logic   uses_rs2;
  logic   legal;
  logic   rs1_pending;
  logic   rs2_pending;
  logic   hazard;

  assign inst     = in_payload.inst;
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};

  always_comb begin
    out_payload            = '0;
    out_payload.pc         = in_payload.pc;
    out_payload.alu_op     = alu_add;
    out_payload.operand_a  = rs1_data;
    out_payload.operand_b  = imm_i;
    out_payload.store_data = rs2_data;
    out_payload.rd         = inst[11:7];
    legal    = 1'b1;
    uses_rs1 = 1'b1;
    uses_rs2 = 1'b0;
    case (inst[6:0])
      opc_op_imm: begin
        out_payload.reg_write = 1'b1;
        case (inst[14:12])
          3'b000:  out_payload.alu_op = alu_add;
          3'b100:  out_payload.alu_op = alu_xor;
          3'b110:  out_payload.alu_op = alu_or;
          3'b111:  out_payload.alu_op = alu_and;
          default: legal = 1'b0;
        endcase
      end
      opc_op: begin
        out_payload.reg_write = 1'b1;
        out_payload.operand_b = rs2_data;
        uses_rs2 = 1'b1;
        case ({inst[31:25], inst[14:12]})
          10'b0000000_000: out_payload.alu_op = alu_add;
          10'b0100000_000: out_payload.alu_op = alu_sub;
          10'b0000000_100: out_payload.alu_op = alu_xor;
          10'b0000000_110: out_payload.alu_op = alu_or;
          10'b0000000_111: out_payload.alu_op = alu_and;
          default:         legal = 1'b0;
        endcase
      end
      opc_lui: begin
        out_payload.reg_write = 1'b1;
        out_payload.alu_op    = alu_pass_b;
        out_payload.operand_b = imm_u;
        uses_rs1 = 1'b0;
      end
      opc_load: begin
        // only LD, funct3 3
        out_payload.reg_write = 1'b1;
        out_payload.is_load   = 1'b1;
        legal = (inst[14:12] == 3'b011);
      end
      opc_store: begin
        out_payload.is_store  = 1'b1;
        out_payload.operand_b = imm_s;
        uses_rs2 = 1'b1;
        legal = (inst[14:12] == 3'b011);
      end
      default: legal = 1'b0;
    endcase
    // anything else retires as a no-op
    if (!legal) begin
      out_payload.reg_write = 1'b0;
      out_payload.is_load   = 1'b0;
      out_payload.is_store  = 1'b0;
      uses_rs1 = 1'b0;
      uses_rs2 = 1'b0;
    end
  end

  // older writers still in flight
  assign rs1_pending = (ex_busy && ex_write && ex_rd == rs1_addr) ||
                       (mem_busy && mem_write && mem_rd == rs1_addr) ||
                       (commit_valid && commit_write && commit_rd == rs1_addr);
  assign rs2_pending = (ex_busy && ex_write && ex_rd == rs2_addr) ||
                       (mem_busy && mem_write && mem_rd == rs2_addr) ||
                       (commit_valid && commit_write && commit_rd == rs2_addr);

  // x0 never waits on a writer
  assign hazard = (uses_rs1 && rs1_addr != '0 && rs1_pending) ||
                  (uses_rs2 && rs2_addr != '0 && rs2_pending);

  assign out_valid = in_valid && !hazard;
  assign in_ready  = out_ready && !hazard;

endmodule

// File: hdl/regfile.sv
/*
  32 x 64 integer registers, two async reads, one write port.
  a write lands at the clock edge, so a same-cycle read sees the old value
*/
module regfile import core_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  reg_idx_t rs1_addr,
  input  reg_idx_t rs2_addr,
  output xword_t   rs1_data,
  output xword_t   rs2_data,
  input  logic     write_valid,
  input  reg_idx_t write_rd,
  input  logic     write_enable,
  input  xword_t   write_data
);

  // x0 has no storage
  xword_t regs [1:31];

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_valid && write_enable && write_rd != '0) begin
      regs[write_rd] <= write_data;
    end
  end

endmodule

// File: hdl/exec_stage.sv
/*
  combinational alu between the ex and mem slots.
  no shifts or compares, the decoder never issues them
*/
module exec_stage import core_pkg::*; (
  input  logic    in_valid,
  output logic    in_ready,
  input  decode_t in_payload,
  output logic    out_valid,
  input  logic    out_ready,
  output exec_t   out_payload
);

  xword_t result;

  always_comb begin
    case (in_payload.alu_op)
      alu_add:    result = in_payload.operand_a + in_payload.operand_b;
      alu_sub:    result = in_payload.operand_a - in_payload.operand_b;
      alu_xor:    result = in_payload.operand_a ^ in_payload.operand_b;
      alu_or:     result = in_payload.operand_a | in_payload.operand_b;
      alu_and:    result = in_payload.operand_a & in_payload.operand_b;
      alu_pass_b: result = in_payload.operand_b;
      default:    result = '0;
    endcase
  end

  assign out_valid = in_valid;
  assign in_ready  = out_ready;

  assign out_payload.pc         = in_payload.pc;
  assign out_payload.result     = result;
  assign out_payload.store_data = in_payload.store_data;
  assign out_payload.rd         = in_payload.rd;
  assign out_payload.reg_write  = in_payload.reg_write;
  assign out_payload.is_load    = in_payload.is_load;
  assign out_payload.is_store   = in_payload.is_store;

endmodule

// File: hdl/mem_wb_stage.sv
/*
  data memory access and commit. request and reply share one handshake, so
  dmem_rdata must be valid while dmem_valid and dmem_ready are both high
*/
module mem_wb_stage import core_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  exec_t    in_payload,
  output logic     dmem_valid,
  input  logic     dmem_ready,
  output logic     dmem_write,
  output xword_t   dmem_addr,
  output xword_t   dmem_wdata,
  input  xword_t   dmem_rdata,
  output logic     commit_valid,
  output xword_t   commit_pc,
  output reg_idx_t commit_rd,
  output logic     commit_write,
  output xword_t   commit_data
);

  logic is_mem;
  logic accept;

  assign is_mem = in_payload.is_load || in_payload.is_store;

  assign dmem_valid = in_valid && is_mem;
  assign dmem_write = in_payload.is_store;
  assign dmem_addr  = in_payload.result;
  assign dmem_wdata = in_payload.store_data;

  // memory ops wait for the handshake, alu ops go through at once
  assign in_ready = !is_mem || dmem_ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= accept;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      commit_pc    <= in_payload.pc;
      commit_rd    <= in_payload.rd;
      commit_write <= in_payload.reg_write && !in_payload.is_store;
      commit_data  <= in_payload.is_load ? dmem_rdata : in_payload.result;
    end
  end

endmodule

// File: hdl/rv_core.sv
/*
  in-order rv64 subset core: addi/xori/ori/andi, add/sub/xor/or/and, lui, ld, sd.
  no branches, csrs or traps; other encodings retire without a register write
*/
module rv_core import core_pkg::*; #(
  parameter xword_t reset_pc = '0
) (
  input  logic     clock,
  input  logic     reset,
  output logic     imem_valid,
  input  logic     imem_ready,
  output xword_t   imem_addr,
  input  inst_t    imem_rdata,
  output logic     dmem_valid,
  input  logic     dmem_ready,
  output logic     dmem_write,
  output xword_t   dmem_addr,
  output xword_t   dmem_wdata,
  input  xword_t   dmem_rdata,
  output logic     commit_valid,
  output xword_t   commit_pc,
  output reg_idx_t commit_rd,
  output logic     commit_write,
  output xword_t   commit_data
);

  logic     if_valid, if_ready, id_valid, id_ready;
  fetch_t   if_payload, id_payload;
  logic     dec_valid, dec_ready, ex_valid, ex_ready;
  decode_t  dec_payload, ex_payload;
  logic     alu_valid, alu_ready, mem_valid, mem_ready;
  exec_t    alu_payload, mem_payload;
  reg_idx_t rs1_addr, rs2_addr;
  xword_t   rs1_data, rs2_data;

  fetch_stage #(.reset_pc(reset_pc)) u_fetch (
    .clock(clock), .reset(reset),
    .imem_valid(imem_valid), .imem_ready(imem_ready),
    .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .out_valid(if_valid), .out_ready(if_ready), .out_payload(if_payload)
  );

  pipe_slot #(.payload_t(fetch_t)) id_slot (
    .clock(clock), .reset(reset),
    .in_valid(if_valid), .in_ready(if_ready), .in_payload(if_payload),
    .out_valid(id_valid), .out_ready(id_ready), .out_payload(id_payload)
  );

  decode_stage u_decode (
    .in_valid(id_valid), .in_ready(id_ready), .in_payload(id_payload),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .ex_busy(ex_valid), .ex_rd(ex_payload.rd), .ex_write(ex_payload.reg_write),
    .mem_busy(mem_valid), .mem_rd(mem_payload.rd), .mem_write(mem_payload.reg_write),
    .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_write(commit_write),
    .out_valid(dec_valid), .out_ready(dec_ready), .out_payload(dec_payload)
  );

  regfile u_regfile (
    .clock(clock), .reset(reset),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .write_valid(commit_valid), .write_rd(commit_rd),
    .write_enable(commit_write), .write_data(commit_data)
  );

  pipe_slot #(.payload_t(decode_t)) ex_slot (
    .clock(clock), .reset(reset),
    .in_valid(dec_valid), .in_ready(dec_ready), .in_payload(dec_payload),
    .out_valid(ex_valid), .out_ready(ex_ready), .out_payload(ex_payload)
  );

  exec_stage u_exec (
    .in_valid(ex_valid), .in_ready(ex_ready), .in_payload(ex_payload),
    .out_valid(alu_valid), .out_ready(alu_ready), .out_payload(alu_payload)
  );

  pipe_slot #(.payload_t(exec_t)) mem_slot (
    .clock(clock), .reset(reset),
    .in_valid(alu_valid), .in_ready(alu_ready), .in_payload(alu_payload),
    .out_valid(mem_valid), .out_ready(mem_ready), .out_payload(mem_payload)
  );

  mem_wb_stage u_mem_wb (
    .clock(clock), .reset(reset),
    .in_valid(mem_valid), .in_ready(mem_ready), .in_payload(mem_payload),
    .dmem_valid(dmem_valid), .dmem_ready(dmem_ready), .dmem_write(dmem_write),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
    .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_rd(commit_rd),
    .commit_write(commit_write), .commit_data(commit_data)
  );

endmodule

// File: verif/tb_rv_core.sv
/*
  random program of 200 kept-set instructions, base x0 loads/stores in a 256-byte window.
  both memories answer with random ready stalls; every commit is checked in program order
*/
module tb_rv_core import core_pkg::*;;

  localparam xword_t reset_pc     = '0;
  localparam int     num_insts    = 200;
  localparam int     reset_cycles = 4;
  // worst case of 16 cycles per instruction
  localparam int     max_cycles   = num_insts * 16 + reset_cycles;

  typedef struct packed {
    xword_t   pc;
    reg_idx_t rd;
    logic     write;
    xword_t   data;
    logic     mem;
    logic     store;
    xword_t   addr;
    xword_t   wdata;
  } expect_t;

  logic     clock;
  logic     reset;
  logic     imem_valid;
  logic     imem_ready;
  xword_t   imem_addr;
  inst_t    imem_rdata;
  logic     dmem_valid;
  logic     dmem_ready;
  logic     dmem_write;
  xword_t   dmem_addr;
  xword_t   dmem_wdata;
  xword_t   dmem_rdata;
  logic     commit_valid;
  xword_t   commit_pc;
  reg_idx_t commit_rd;
  logic     commit_write;
  xword_t   commit_data;

  integer  seed = 71441;
  inst_t   prog [num_insts];
  xword_t  dmem_words [32];
  xword_t  mregs [32];
  xword_t  mmem [32];
  logic    last_write;
  xword_t  last_addr;
  xword_t  last_wdata;
  xword_t  fetch_addr;
  int      num_committed;
  int      cycles;
  expect_t exp_c;

  rv_core #(.reset_pc(reset_pc)) u_rv_core (
    .clock(clock), .reset(reset),
    .imem_valid(imem_valid), .imem_ready(imem_ready),
    .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .dmem_valid(dmem_valid), .dmem_ready(dmem_ready), .dmem_write(dmem_write),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
    .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_rd(commit_rd),
    .commit_write(commit_write), .commit_data(commit_data)
  );

  always #20 clock = !clock;

  // registers limited to x0..x7 so dependent pairs show up often
  function automatic inst_t random_inst();
    logic [31:0] rnd;
    int unsigned kind;
    logic [2:0]  f3;
    logic [9:0]  f73;
    logic [11:0] off;
    rnd  = $random(seed);
    kind = {$random(seed)} % 100;
    off  = {4'b0, rnd[25:21], 3'b0};
    case (rnd[27:26])
      2'd0:    f3 = 3'b000;
      2'd1:    f3 = 3'b100;
      2'd2:    f3 = 3'b110;
      default: f3 = 3'b111;
    endcase
    case (rnd[30:28])
      3'd0:    f73 = 10'b0000000_000;
      3'd1:    f73 = 10'b0100000_000;
      3'd2:    f73 = 10'b0000000_100;
      3'd3:    f73 = 10'b0000000_110;
      default: f73 = 10'b0000000_111;
    endcase
    if (kind < 5) begin
      // custom-0 opcode, not decoded
      return {rnd[24:0], 7'b0001011};
    end else if (kind < 35) begin
      return {rnd[20:9], 2'b0, rnd[5:3], f3, 2'b0, rnd[2:0], opc_op_imm};
    end else if (kind < 65) begin
      return {f73[9:3], 2'b0, rnd[8:6], 2'b0, rnd[5:3], f73[2:0], 2'b0, rnd[2:0], opc_op};
    end else if (kind < 75) begin
      return {rnd[31:12], 2'b0, rnd[2:0], opc_lui};
    end else if (kind < 87) begin
      return {off, 5'd0, 3'b011, 2'b0, rnd[2:0], opc_load};
    end else begin
      return {off[11:5], 2'b0, rnd[8:6], 5'd0, 3'b011, off[4:0], opc_store};
    end
  endfunction

  // architectural model: one instruction in, expected commit out
  function automatic expect_t retire_model(input inst_t inst, input xword_t pc);
    expect_t e;
    xword_t  a;
    xword_t  b;
    xword_t  imm_i;
    xword_t  imm_s;
    a     = mregs[inst[19:15]];
    b     = mregs[inst[24:20]];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    e     = '0;
    e.pc  = pc;
    e.rd  = inst[11:7];
    case (inst[6:0])
      opc_op_imm: begin
        e.write = 1'b1;
        case (inst[14:12])
          3'b000:  e.data = a + imm_i;
          3'b100:  e.data = a ^ imm_i;
          3'b110:  e.data = a | imm_i;
          3'b111:  e.data = a & imm_i;
          default: e.write = 1'b0;
        endcase
      end
      opc_op: begin
        e.write = 1'b1;
        case ({inst[31:25], inst[14:12]})
          10'b0000000_000: e.data = a + b;
          10'b0100000_000: e.data = a - b;
          10'b0000000_100: e.data = a ^ b;
          10'b0000000_110: e.data = a | b;
          10'b0000000_111: e.data = a & b;
          default:         e.write = 1'b0;
        endcase
      end
      opc_lui: begin
        e.write = 1'b1;
        e.data  = {{32{inst[31]}}, inst[31:12], 12'b0};
      end
      opc_load: begin
        if (inst[14:12] == 3'b011) begin
          e.write = 1'b1;
          e.mem   = 1'b1;
          e.addr  = a + imm_i;
          e.data  = mmem[e.addr[7:3]];
        end
      end
      opc_store: begin
        if (inst[14:12] == 3'b011) begin
          e.mem   = 1'b1;
          e.store = 1'b1;
          e.addr  = a + imm_s;
          e.wdata = b;
          mmem[e.addr[7:3]] = b;
        end
      end
      default: ;
    endcase
    if (e.write && e.rd != '0) begin
      mregs[e.rd] = e.data;
    end
    return e;
  endfunction

  task automatic value_mismatch(input string name, input xword_t expected, input xword_t actual);
    $display("[ERROR] time %0t: %s expected %h, got %h", $time, name, expected, actual);
    $display("Test failures found");
    $fatal(1);
  endtask

  initial begin
    clock      = 1'b0;
    reset      = 1'b1;
    imem_ready = 1'b0;
    imem_rdata = '0;
    dmem_ready = 1'b0;
    dmem_rdata = '0;
    for (int i = 0; i < 32; i++) begin
      dmem_words[i] = '0;
      mregs[i]      = '0;
      mmem[i]       = '0;
    end
    for (int i = 0; i < num_insts; i++) begin
      prog[i] = random_inst();
    end
    repeat (reset_cycles) @(posedge clock);
    #2 reset = 1'b0;
  end

  // memory models: handshakes sampled at the edge, replies driven just after it
  always @(posedge clock) begin
    if (!reset && imem_valid && imem_ready) begin
      assert (imem_addr == fetch_addr)
        else value_mismatch("imem_addr", fetch_addr, imem_addr);
      fetch_addr = fetch_addr + 4;
    end
    if (!reset && dmem_valid && dmem_ready) begin
      if (dmem_write) begin
        dmem_words[dmem_addr[7:3]] = dmem_wdata;
      end
      last_write <= dmem_write;
      last_addr  <= dmem_addr;
      last_wdata <= dmem_wdata;
    end
    if (reset) begin
      fetch_addr = reset_pc;
    end
    #2;
    imem_ready = ({$random(seed)} % 4) != 0;
    dmem_ready = ({$random(seed)} % 3) != 0;
    // past the program end, feed addi x0, x0, 0
    if (((imem_addr - reset_pc) >> 2) < num_insts) begin
      imem_rdata = prog[(imem_addr - reset_pc) >> 2];
    end else begin
      imem_rdata = 32'h0000_0013;
    end
    dmem_rdata = dmem_words[dmem_addr[7:3]];
  end

  always @(posedge clock) begin
    if (reset) begin
      num_committed = 0;
      cycles        = 0;
    end else begin
      cycles = cycles + 1;
      if (commit_valid) begin
        exp_c = retire_model(prog[num_committed], reset_pc + 4 * num_committed);
        assert (commit_pc == exp_c.pc)
          else value_mismatch("commit_pc", exp_c.pc, commit_pc);
        assert (commit_write == exp_c.write)
          else value_mismatch("commit_write", xword_t'(exp_c.write), xword_t'(commit_write));
        if (exp_c.write) begin
          assert (commit_rd == exp_c.rd)
            else value_mismatch("commit_rd", xword_t'(exp_c.rd), xword_t'(commit_rd));
          assert (commit_data == exp_c.data)
            else value_mismatch("commit_data", exp_c.data, commit_data);
        end
        // the data handshake was one cycle before this commit
        if (exp_c.mem) begin
          assert (last_write == exp_c.store)
            else value_mismatch("dmem_write", xword_t'(exp_c.store), xword_t'(last_write));
          assert (last_addr == exp_c.addr)
            else value_mismatch("dmem_addr", exp_c.addr, last_addr);
          if (exp_c.store) begin
            assert (last_wdata == exp_c.wdata)
              else value_mismatch("dmem_wdata", exp_c.wdata, last_wdata);
          end
        end
        num_committed = num_committed + 1;
      end
      if (num_committed == num_insts) begin
        $display("All tests passed!");
        $finish;
      end else if (cycles >= max_cycles) begin
        $display("timeout: only %0d of %0d instructions committed in %0d cycles",
                 num_committed, num_insts, cycles);
        $display("Test failures found");
        $fatal(1);
      end
    end
  end

endmodule

// File: build.f
hdl/core_pkg.sv
hdl/pipe_slot.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/regfile.sv
hdl/exec_stage.sv
hdl/mem_wb_stage.sv
hdl/rv_core.sv
verif/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - hdl/core_pkg.sv
  - hdl/pipe_slot.sv
  - hdl/fetch_stage.sv
  - hdl/decode_stage.sv
  - hdl/regfile.sv
  - hdl/exec_stage.sv
  - hdl/mem_wb_stage.sv
  - hdl/rv_core.sv
  - target: test
    files:
      - verif/tb_rv_core.sv
